// File: hdl/filterPkg.sv
package filterPkg;

    // Recursion state and factor format
    parameter int STATE_W = 24;
    parameter int FRAC = 15;
    parameter int FACTOR_W = 16;

    // Names the bank currently being written
    typedef enum logic [1:0] {
        PHASE0 = 2'd0,
        PHASE1 = 2'd1,
        PHASE2 = 2'd2,
        PHASE3 = 2'd3
    } phaseT;

    // Symbol to signed level, 2*sym - (2^symW - 1)
    function automatic logic signed [STATE_W-1:0] levelOf(input int sym, input int symW);
        int lvl;
        lvl = 2 * sym - ((1 << symW) - 1);
        return STATE_W'(lvl);
    endfunction

endpackage

// File: hdl/batchSequencer.sv
`timescale 1ns/1ps

module batchSequencer #(
    parameter int DEPTH = 32
) (
    input  logic                     clk,
    input  logic                     arstN,
    output logic [$clog2(DEPTH)-1:0] batCount,
    output logic [$clog2(DEPTH)-1:0] batCountRev,
    output filterPkg::phaseT         phase,
    output logic                     phaseEnd,
    output logic                     warm
);
    localparam int ADDR_W = $clog2(DEPTH);
    localparam logic [ADDR_W-1:0] LAST = ADDR_W'(DEPTH - 1);

    logic [1:0] endCount;

    assign phaseEnd = (batCount == LAST);
    assign batCountRev = LAST - batCount;

    // Batch address, wraps at DEPTH
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            batCount <= '0;
        end else begin
            batCount <= batCount + ADDR_W'(1);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            phase <= filterPkg::PHASE0;
        end else if (phaseEnd) begin
            phase <= filterPkg::phaseT'(phase + 2'd1);
        end
    end

    // Warm after the fourth completed phase
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            endCount <= 2'd0;
            warm <= 1'b0;
        end else if (phaseEnd && !warm) begin
            if (endCount == 2'd3) begin
                warm <= 1'b1;
            end else begin
                endCount <= endCount + 2'd1;
            end
        end
    end

endmodule

// File: hdl/sampleBank.sv
`timescale 1ns/1ps

module sampleBank #(
    parameter int DEPTH = 32,
    parameter int SYM_W = 3
) (
    input  logic                     clk,
    input  logic [SYM_W-1:0]         sample,
    input  filterPkg::phaseT         phase,
    input  logic [$clog2(DEPTH)-1:0] batCount,
    input  logic [$clog2(DEPTH)-1:0] batCountRev,
    output logic [SYM_W-1:0]         lhSym,
    output logic [SYM_W-1:0]         fwdSym,
    output logic [SYM_W-1:0]         bwdSym
);
    // Four rotating banks, indexed by bank number
    logic [SYM_W-1:0] mem [4][DEPTH];

    logic [1:0] wrBank;
    logic [1:0] lhBank;
    logic [1:0] oldBank;

    // Bank p is written, p-1 looked ahead, p-3 filtered both ways
    assign wrBank = phase;
    assign lhBank = phase - 2'd1;
    assign oldBank = phase - 2'd3;

    always_ff @(posedge clk) begin
        mem[wrBank][batCount] <= sample;
    end

    // Newest finished batch, read in reverse
    always_ff @(posedge clk) begin
        lhSym <= mem[lhBank][batCountRev];
    end

    // Oldest batch, both directions at once
    always_ff @(posedge clk) begin
        fwdSym <= mem[oldBank][batCount];
        bwdSym <= mem[oldBank][batCountRev];
    end

endmodule

// File: hdl/recursionStage.sv
`timescale 1ns/1ps

module recursionStage #(
    parameter logic signed [filterPkg::FACTOR_W-1:0] FACTOR = 16'sd16384
) (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic signed [filterPkg::STATE_W-1:0] level,
    input  logic                                load,
    input  logic signed [filterPkg::STATE_W-1:0] loadVal,
    output logic signed [filterPkg::STATE_W-1:0] state
);
    localparam int STATE_W = filterPkg::STATE_W;
    localparam int PROD_W = filterPkg::STATE_W + filterPkg::FACTOR_W;

    logic signed [STATE_W-1:0] base;
    logic signed [PROD_W-1:0]  product;
    logic signed [PROD_W-1:0]  scaled;
    logic signed [STATE_W-1:0] nextState;

    // Start value takes the place of the fed-back state
    assign base = load ? loadVal : state;
    assign product = base * FACTOR;
    assign scaled = product >>> filterPkg::FRAC;

    // Wraps at STATE_W bits
    assign nextState = scaled[STATE_W-1:0] + level;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= '0;
        end else begin
            state <= nextState;
        end
    end

endmodule

// File: hdl/bidirFilterCore.sv
`timescale 1ns/1ps

module bidirFilterCore #(
    parameter int DEPTH = 32,
    parameter int SYM_W = 3,
    parameter logic signed [filterPkg::FACTOR_W-1:0] FWD_FACTOR = 16'sd24576,
    parameter logic signed [filterPkg::FACTOR_W-1:0] BWD_FACTOR = 16'sd16384
) (
    input  logic                               clk,
    input  logic                               arstN,
    input  logic [SYM_W-1:0]                   lhSym,
    input  logic [SYM_W-1:0]                   fwdSym,
    input  logic [SYM_W-1:0]                   bwdSym,
    input  filterPkg::phaseT                   phase,
    input  logic [$clog2(DEPTH)-1:0]           batCount,
    input  logic [$clog2(DEPTH)-1:0]           batCountRev,
    input  logic                               phaseEnd,
    input  logic                               warm,
    output logic signed [filterPkg::STATE_W:0] out,
    output logic                               outValid
);
    localparam int ADDR_W = $clog2(DEPTH);
    localparam int STATE_W = filterPkg::STATE_W;

    logic signed [STATE_W-1:0] lhLevel;
    logic signed [STATE_W-1:0] fwdLevel;
    logic signed [STATE_W-1:0] bwdLevel;
    logic signed [STATE_W-1:0] lhState;
    logic signed [STATE_W-1:0] fwdState;
    logic signed [STATE_W-1:0] bwdState;
    logic signed [STATE_W-1:0] lhInit;

    logic              endDly;
    logic              rdFirst;
    logic              bwdFirst;
    logic              fwdLoad;
    logic [ADDR_W-1:0] addrDly [3];
    logic [ADDR_W-1:0] addrRevDly [3];
    logic [2:0]        selDly;
    logic [2:0]        warmDly;
    logic              wrSel;
    logic              rdSel;

    logic signed [STATE_W-1:0] fwdMem [2][DEPTH];
    logic signed [STATE_W-1:0] bwdMem [2][DEPTH];
    logic signed [STATE_W-1:0] fwdRd;
    logic signed [STATE_W-1:0] bwdRd;

    // Lookahead sees the bank data directly, fwd and bwd one stage later
    assign lhLevel = filterPkg::levelOf(int'(lhSym), SYM_W);

    always_ff @(posedge clk) begin
        fwdLevel <= filterPkg::levelOf(int'(fwdSym), SYM_W);
        bwdLevel <= filterPkg::levelOf(int'(bwdSym), SYM_W);
    end

    // rdFirst: first lookahead read, bwdFirst: first fwd/bwd level
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            endDly <= 1'b0;
            rdFirst <= 1'b0;
            bwdFirst <= 1'b0;
            addrDly[0] <= '0;
            addrDly[1] <= '0;
            addrDly[2] <= '0;
            addrRevDly[0] <= '0;
            addrRevDly[1] <= '0;
            addrRevDly[2] <= '0;
            selDly <= '0;
            warmDly <= '0;
        end else begin
            endDly <= phaseEnd;
            rdFirst <= endDly;
            bwdFirst <= rdFirst;
            addrDly[0] <= batCount;
            addrDly[1] <= addrDly[0];
            addrDly[2] <= addrDly[1];
            addrRevDly[0] <= batCountRev;
            addrRevDly[1] <= addrRevDly[0];
            addrRevDly[2] <= addrRevDly[1];
            selDly <= {selDly[1:0], phase[0]};
            warmDly <= {warmDly[1:0], warm};
        end
    end

    // Lookahead final state is still on lhState during rdFirst
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lhInit <= '0;
        end else if (rdFirst) begin
            lhInit <= lhState;
        end
    end

    // Forward starts clean on batch 0, then never restarts
    assign fwdLoad = bwdFirst && (phase == filterPkg::PHASE3) && !warm;

    recursionStage #(.FACTOR(BWD_FACTOR)) lookahead_i (
        .clk(clk), .arstN(arstN), .level(lhLevel),
        .load(rdFirst), .loadVal('0), .state(lhState)
    );

    recursionStage #(.FACTOR(FWD_FACTOR)) forward_i (
        .clk(clk), .arstN(arstN), .level(fwdLevel),
        .load(fwdLoad), .loadVal('0), .state(fwdState)
    );

    recursionStage #(.FACTOR(BWD_FACTOR)) backward_i (
        .clk(clk), .arstN(arstN), .level(bwdLevel),
        .load(bwdFirst), .loadVal(lhInit), .state(bwdState)
    );

    // Ping-pong by delayed phase parity
    assign wrSel = selDly[2];
    assign rdSel = ~wrSel;

    always_ff @(posedge clk) begin
        fwdMem[wrSel][addrDly[2]] <= fwdState;
        bwdMem[wrSel][addrRevDly[2]] <= bwdState;
    end

    assign fwdRd = fwdMem[rdSel][addrDly[2]];
    assign bwdRd = bwdMem[rdSel][addrDly[2]];

    // One extra bit, so no wrap on the sum
    always_ff @(posedge clk) begin
        out <= {fwdRd[STATE_W-1], fwdRd} + {bwdRd[STATE_W-1], bwdRd};
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= warmDly[2];
        end
    end

endmodule

// File: hdl/batchFilterTop.sv
`timescale 1ns/1ps

module batchFilterTop #(
    parameter int DEPTH = 32,
    parameter int SYM_W = 3,
    parameter logic signed [filterPkg::FACTOR_W-1:0] FWD_FACTOR = 16'sd24576,
    parameter logic signed [filterPkg::FACTOR_W-1:0] BWD_FACTOR = 16'sd16384
) (
    input  logic                               clk,
    input  logic                               arstN,
    input  logic [SYM_W-1:0]                   sample,
    output logic signed [filterPkg::STATE_W:0] out,
    output logic                               outValid
);
    localparam int ADDR_W = $clog2(DEPTH);

    logic [ADDR_W-1:0] batCount;
    logic [ADDR_W-1:0] batCountRev;
    filterPkg::phaseT  phase;
    logic              phaseEnd;
    logic              warm;
    logic [SYM_W-1:0]  lhSym;
    logic [SYM_W-1:0]  fwdSym;
    logic [SYM_W-1:0]  bwdSym;

    batchSequencer #(.DEPTH(DEPTH)) seq_i (
        .clk(clk), .arstN(arstN), .batCount(batCount), .batCountRev(batCountRev),
        .phase(phase), .phaseEnd(phaseEnd), .warm(warm)
    );

    sampleBank #(.DEPTH(DEPTH), .SYM_W(SYM_W)) bank_i (
        .clk(clk), .sample(sample), .phase(phase),
        .batCount(batCount), .batCountRev(batCountRev),
        .lhSym(lhSym), .fwdSym(fwdSym), .bwdSym(bwdSym)
    );

    bidirFilterCore #(
        .DEPTH(DEPTH), .SYM_W(SYM_W),
        .FWD_FACTOR(FWD_FACTOR), .BWD_FACTOR(BWD_FACTOR)
    ) core_i (
        .clk(clk), .arstN(arstN),
        .lhSym(lhSym), .fwdSym(fwdSym), .bwdSym(bwdSym),
        .phase(phase), .batCount(batCount), .batCountRev(batCountRev),
        .phaseEnd(phaseEnd), .warm(warm),
        .out(out), .outValid(outValid)
    );

endmodule

// File: tests/batchFilterTb.sv
`timescale 1ns/1ps

module batchFilterTb;

    localparam int DEPTH = 32;
    localparam int SYM_W = 3;
    localparam int STATE_W = filterPkg::STATE_W;
    localparam int NUM_BATCHES = 17;
    localparam int NUM_CHECKED = 12;
    localparam int NUM_SYMS = NUM_BATCHES * DEPTH;
    localparam int RESET_CYCLES = 16;
    localparam int VALID_TIMEOUT = 8 * DEPTH;
    // Q1.15 factors for 0.75 forward and 0.5 lookahead and backward
    localparam longint FWD_Q15 = 24576;
    localparam longint BWD_Q15 = 16384;

    logic                    clk;
    logic                    arstN;
    logic [SYM_W-1:0]        sample;
    logic signed [STATE_W:0] out;
    logic                    outValid;

    logic [SYM_W-1:0] syms [NUM_SYMS];
    longint levels [NUM_SYMS];
    longint fwdModel [NUM_SYMS];
    longint bwdModel [NUM_SYMS];
    longint lhModel [NUM_BATCHES];
    longint expQ [$];
    logic [31:0] rngState;

    batchFilterTop dut_i (
        .clk(clk), .arstN(arstN), .sample(sample), .out(out), .outValid(outValid)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Two's-complement wrap to STATE_W bits
    function automatic longint wrapState(input longint x);
        longint y;
        y = x & ((longint'(1) << STATE_W) - 1);
        if (y >= (longint'(1) << (STATE_W - 1))) begin
            y = y - (longint'(1) << STATE_W);
        end
        return y;
    endfunction

    function automatic longint stepState(input longint s, input longint factor,
                                         input longint lvl);
        longint scaled;
        scaled = (s * factor) >>> 15;
        return wrapState(scaled + lvl);
    endfunction

    // 0 random, 1 constant, 2 all zeros, 3 all ones
    function automatic int kindOf(input int b);
        case (b)
            2, 9, 11: return 1;
            4, 6: return 2;
            5, 7: return 3;
            default: return 0;
        endcase
    endfunction

    task automatic buildStimulus();
        logic [SYM_W-1:0] constSym;
        int kind;
        rngState = 32'd20;
        for (int b = 0; b < NUM_BATCHES; b++) begin
            kind = kindOf(b);
            rngState = xorshift32(rngState);
            constSym = rngState[SYM_W-1:0];
            for (int k = 0; k < DEPTH; k++) begin
                rngState = xorshift32(rngState);
                case (kind)
                    1: syms[b * DEPTH + k] = constSym;
                    2: syms[b * DEPTH + k] = '0;
                    3: syms[b * DEPTH + k] = '1;
                    default: syms[b * DEPTH + k] = rngState[SYM_W-1:0];
                endcase
            end
        end
    endtask

    task automatic buildModel();
        longint s;
        for (int i = 0; i < NUM_SYMS; i++) begin
            levels[i] = 2 * longint'(syms[i]) - ((longint'(1) << SYM_W) - 1);
        end
        // Forward never restarts
        s = 0;
        for (int i = 0; i < NUM_SYMS; i++) begin
            s = stepState(s, FWD_Q15, levels[i]);
            fwdModel[i] = s;
        end
        // Lookahead from zero over each batch in reverse
        for (int b = 0; b < NUM_BATCHES; b++) begin
            s = 0;
            for (int k = DEPTH - 1; k >= 0; k--) begin
                s = stepState(s, BWD_Q15, levels[b * DEPTH + k]);
            end
            lhModel[b] = s;
        end
        // Backward over batch b starts from the lookahead of batch b+1
        for (int b = 0; b < NUM_BATCHES - 1; b++) begin
            s = lhModel[b + 1];
            for (int k = DEPTH - 1; k >= 0; k--) begin
                s = stepState(s, BWD_Q15, levels[b * DEPTH + k]);
                bwdModel[b * DEPTH + k] = s;
            end
        end
        for (int i = 0; i < NUM_CHECKED * DEPTH; i++) begin
            expQ.push_back(fwdModel[i] + bwdModel[i]);
        end
    endtask

    task automatic driveSymbols();
        for (int i = 0; i < NUM_SYMS; i++) begin
            sample <= syms[i];
            @(posedge clk);
        end
    endtask

    task automatic checkOutputs();
        int cyc;
        int b;
        int k;
        longint got;
        longint want;
        cyc = 0;
        do begin
            @(negedge clk);
            cyc++;
            if (cyc > VALID_TIMEOUT) begin
                $display("Timed out waiting for outValid to go high after reset");
                $display("test failed");
                $fatal(1, "no valid output");
            end
            // First four batches are still arriving
            if (cyc <= 4 * DEPTH + 1) begin
                coldQuiet: assert (!outValid) else begin
                    $display("outValid went high too early at time %0t", $time);
                    $display("test failed");
                    $fatal(1, "early outValid");
                end
            end
        end while (!outValid);

        for (int i = 0; i < NUM_CHECKED * DEPTH; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            b = i / DEPTH;
            k = i % DEPTH;
            got = longint'(out);
            want = expQ.pop_front();
            validHeld: assert (outValid) else begin
                $display("outValid dropped at time %0t in batch %0d", $time, b);
                $display("test failed");
                $fatal(1, "outValid not held");
            end
            valueMatch: assert (got == want) else begin
                $display("MISMATCH at %0t: batch %0d sample %0d out %0d expected %0d",
                         $time, b, k, got, want);
                $display("test failed");
                $fatal(1, "output value differs from model");
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        arstN = 1'b0;
        sample = '0;
        buildStimulus();
        buildModel();
        repeat (RESET_CYCLES) @(posedge clk);
        arstN <= 1'b1;
        fork
            driveSymbols();
            checkOutputs();
        join
        $display("test passed");
        $finish;
    end

endmodule

// File: sources.f
hdl/filterPkg.sv
hdl/batchSequencer.sv
hdl/sampleBank.sv
hdl/recursionStage.sv
hdl/bidirFilterCore.sv
hdl/batchFilterTop.sv
tests/batchFilterTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run batchFilterTb with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module batchFilterTb -Mdir obj_dir -f sources.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/VbatchFilterTb
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
fi

exit "$status"
